// File: flist.f
hw/mcu_bus_pkg.sv
hw/key_input.sv
hw/io_registers.sv
hw/data_bus_decode.sv
hw/video_ram.sv
hw/mcu_bus_top.sv
test/mcu_bus_assertions.sv
test/tb_mcu_bus.sv

// File: test/tb_mcu_bus.sv
`timescale 1ns/1ps

module tb_mcu_bus
  import mcu_bus_pkg::*;
();

  logic       clk;
  logic       reset_n;
  logic       clk_en;
  logic       write_en;
  logic       read_en;
  mem_addr_t  mem_addr;
  nibble_t    write_data;
  nibble_t    input_k0;
  nibble_t    input_k1;
  vram_addr_t display_addr;
  nibble_t    read_data;
  nibble_t    display_data;
  logic [1:0] interrupt_req;
  integer     seed;

  mcu_bus_top #(
    .RAM_DEPTH (RAM_DEFAULT_DEPTH)
  ) dut (
    .clk           (clk),
    .reset_n       (reset_n),
    .clk_en        (clk_en),
    .write_en      (write_en),
    .read_en       (read_en),
    .mem_addr      (mem_addr),
    .write_data    (write_data),
    .input_k0      (input_k0),
    .input_k1      (input_k1),
    .display_addr  (display_addr),
    .read_data     (read_data),
    .display_data  (display_data),
    .interrupt_req (interrupt_req)
  );

  bind mcu_bus_top mcu_bus_assertions u_mcu_bus_assertions (
    .clk           (clk),
    .reset_n       (reset_n),
    .clk_en        (clk_en),
    .write_en      (write_en),
    .read_en       (read_en),
    .mem_addr      (mem_addr),
    .read_data     (read_data),
    .input_k0      (input_k0),
    .input_k1      (input_k1),
    .interrupt_req (interrupt_req)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Simulation failed");
    $fatal(1, "run stopped");
  endtask

  always @(posedge clk) begin
    if (dut.u_mcu_bus_assertions.error_count != 0) begin
      abort_run("a bus assertion failed");
    end
  end

  task automatic compare_nibble(input string name, input nibble_t actual, input nibble_t expected);
    if (actual !== expected) begin
      $display("error at %0d ns: %s is %h, expected %h", $time, name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  task automatic compare_irq(input string name, input logic [1:0] actual,
                             input logic [1:0] expected);
    if (actual !== expected) begin
      $display("error at %0d ns: %s is %b, expected %b", $time, name, actual, expected);
      abort_run("value mismatch");
    end
  endtask

  function automatic mem_addr_t io_addr(input logic [7:0] offset);
    return {IO_PAGE, offset};
  endfunction

  task automatic bus_write(input mem_addr_t addr, input nibble_t data);
    @(negedge clk);
    write_en   = 1'b1;
    mem_addr   = addr;
    write_data = data;
    @(negedge clk);
    write_en = 1'b0;
  endtask

  // Two edges cover both RAM/IO and video read latency
  task automatic read_expect(input mem_addr_t addr, input nibble_t expected);
    @(negedge clk);
    read_en  = 1'b1;
    mem_addr = addr;
    @(negedge clk);
    read_en = 1'b0;
    @(negedge clk);
    compare_nibble($sformatf("read_data (addr %h)", addr), read_data, expected);
  endtask

  task automatic display_expect(input vram_addr_t addr, input nibble_t expected);
    @(negedge clk);
    display_addr = addr;
    @(negedge clk);
    compare_nibble($sformatf("display_data (index %0d)", addr), display_data, expected);
  endtask

  task automatic wait_irq(input int bit_index);
    int cycles;
    cycles = 0;
    while ((interrupt_req[bit_index] !== 1'b1) && (cycles < 20)) begin
      @(negedge clk);
      cycles++;
    end
    if (interrupt_req[bit_index] !== 1'b1) begin
      abort_run($sformatf("timeout waiting for interrupt_req bit %0d", bit_index));
    end
  endtask

  task automatic check_irq_quiet(input int cycles);
    repeat (cycles) begin
      @(negedge clk);
      compare_irq("interrupt_req", interrupt_req, 2'b00);
    end
  endtask

  task automatic test_reset_defaults();
    compare_irq("interrupt_req", interrupt_req, 2'b00);
    read_expect(io_addr(IO_K0_MASK), 4'h0);
    read_expect(io_addr(IO_K1_MASK), 4'h0);
    read_expect(io_addr(IO_K0_RELATION), 4'hF);
  endtask

  task automatic test_main_ram();
    mem_addr_t addrs [20];
    nibble_t   model [RAM_DEFAULT_DEPTH];
    for (int i = 0; i < 20; i++) begin
      addrs[i] = mem_addr_t'($unsigned($random(seed)) % RAM_DEFAULT_DEPTH);
      model[addrs[i]] = nibble_t'($random(seed));
      bus_write(addrs[i], model[addrs[i]]);
    end
    // Repeated addresses hold the last write
    for (int i = 0; i < 20; i++) begin
      read_expect(addrs[i], model[addrs[i]]);
    end
    // Known nonzero value ahead of the unmapped read
    read_expect(io_addr(IO_K0_RELATION), 4'hF);
    read_expect(12'h500, 4'h0);
  endtask

  task automatic test_video_ram();
    int      idx [4];
    nibble_t lo [4];
    nibble_t hi [4];
    idx = '{0, 1, 37, 79};
    for (int i = 0; i < 4; i++) begin
      lo[i] = nibble_t'($random(seed));
      hi[i] = nibble_t'($random(seed));
      bus_write(mem_addr_t'(VRAM_LO_BASE + idx[i]), lo[i]);
      bus_write(mem_addr_t'(VRAM_HI_BASE + idx[i]), hi[i]);
    end
    for (int i = 0; i < 4; i++) begin
      read_expect(mem_addr_t'(VRAM_LO_BASE + idx[i]), lo[i]);
      read_expect(mem_addr_t'(VRAM_HI_BASE + idx[i]), hi[i]);
      display_expect(vram_addr_t'(idx[i]), lo[i]);
      display_expect(vram_addr_t'(idx[i] + VRAM_SEG_SIZE), hi[i]);
    end
    // Past the end falls back to index 0
    display_expect(8'd200, lo[0]);
  endtask

  task automatic test_io_registers();
    bus_write(io_addr(IO_K0_MASK), 4'h5);
    bus_write(io_addr(IO_K1_MASK), 4'hA);
    bus_write(io_addr(IO_K0_RELATION), 4'h6);
    read_expect(io_addr(IO_K0_MASK), 4'h5);
    read_expect(io_addr(IO_K1_MASK), 4'hA);
    read_expect(io_addr(IO_K0_RELATION), 4'h6);
    // Masks off before moving the keys
    bus_write(io_addr(IO_K0_MASK), 4'h0);
    bus_write(io_addr(IO_K1_MASK), 4'h0);
    @(negedge clk);
    input_k0 = 4'hC;
    input_k1 = 4'h3;
    read_expect(io_addr(IO_K0_VALUE), 4'hC);
    read_expect(io_addr(IO_K1_VALUE), 4'h3);
    @(negedge clk);
    input_k0 = 4'h0;
    input_k1 = 4'h0;
    check_irq_quiet(4);
  endtask

  task automatic test_k0_interrupt();
    bus_write(io_addr(IO_K0_RELATION), 4'h0);
    bus_write(io_addr(IO_K0_MASK), 4'h1);
    check_irq_quiet(2);
    @(negedge clk);
    input_k0 = 4'h1;
    wait_irq(0);
    compare_irq("interrupt_req", interrupt_req, 2'b01);
    read_expect(io_addr(IO_K0_FACTOR), 4'h1);
    compare_irq("interrupt_req", interrupt_req, 2'b00);
    // Bit 2 is masked off
    @(negedge clk);
    input_k0 = 4'h5;
    check_irq_quiet(4);
    @(negedge clk);
    input_k0 = 4'h1;
    check_irq_quiet(4);
  endtask

  task automatic test_k1_interrupt();
    @(negedge clk);
    input_k1 = 4'h8;
    check_irq_quiet(3);
    bus_write(io_addr(IO_K1_MASK), 4'h8);
    @(negedge clk);
    input_k1 = 4'h0;
    wait_irq(1);
    compare_irq("interrupt_req", interrupt_req, 2'b10);
    read_expect(io_addr(IO_K1_FACTOR), 4'h1);
    compare_irq("interrupt_req", interrupt_req, 2'b00);
    // Rising edge on K1 is ignored
    @(negedge clk);
    input_k1 = 4'h8;
    check_irq_quiet(4);
  endtask

  initial begin
    seed         = 78919;
    reset_n      = 1'b0;
    clk_en       = 1'b1;
    write_en     = 1'b0;
    read_en      = 1'b0;
    mem_addr     = '0;
    write_data   = '0;
    input_k0     = '0;
    input_k1     = '0;
    display_addr = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;

    test_reset_defaults();
    test_main_ram();
    test_video_ram();
    test_io_registers();
    test_k0_interrupt();
    test_k1_interrupt();
    repeat (2) @(negedge clk);

    if (dut.u_mcu_bus_assertions.error_count == 0) begin
      $display("Simulation completed successfully");
      $finish;
    end else begin
      $display("Simulation failed");
      $fatal(1, "bus assertions reported errors");
    end
  end

endmodule

// File: test/mcu_bus_assertions.sv
`timescale 1ns/1ps

module mcu_bus_assertions
  import mcu_bus_pkg::*;
(
  input logic       clk,
  input logic       reset_n,
  input logic       clk_en,
  input logic       write_en,
  input logic       read_en,
  input mem_addr_t  mem_addr,
  input nibble_t    read_data,
  input nibble_t    input_k0,
  input nibble_t    input_k1,
  input logic [1:0] interrupt_req
);

  int   error_count = 0;
  logic factor_read;

  assign factor_read = clk_en && read_en &&
                       ((mem_addr == {IO_PAGE, IO_K0_FACTOR}) ||
                        (mem_addr == {IO_PAGE, IO_K1_FACTOR}));

  // Strobes are exclusive
  assert property (@(posedge clk) disable iff (!reset_n) !(write_en && read_en))
    else begin
      error_count++;
      $error("write_en and read_en high in the same cycle");
    end

  // No request right out of reset
  assert property (@(posedge clk) $rose(reset_n) |-> (interrupt_req == 2'b00))
    else begin
      error_count++;
      $error("interrupt_req not clear after reset");
    end

  // Video reads update read_data one edge late, hence the second idle cycle
  assert property (@(posedge clk) disable iff (!reset_n)
    (clk_en && !read_en && !$past(read_en)) |=> $stable(read_data))
    else begin
      error_count++;
      $error("read_data changed without a read");
    end

  // A factor read clears the request when the keys hold still
  assert property (@(posedge clk) disable iff (!reset_n)
    (factor_read && ($past(input_k0) == $past(input_k0, 2)) &&
     ($past(input_k1) == $past(input_k1, 2))) |=> (interrupt_req == 2'b00))
    else begin
      error_count++;
      $error("interrupt_req still set after factor read");
    end

endmodule

// File: hw/mcu_bus_top.sv
`timescale 1ns/1ps

module mcu_bus_top
  import mcu_bus_pkg::*;
#(
  parameter int RAM_DEPTH = RAM_DEFAULT_DEPTH
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  logic       write_en,
  input  logic       read_en,
  input  mem_addr_t  mem_addr,
  input  nibble_t    write_data,
  input  nibble_t    input_k0,
  input  nibble_t    input_k1,
  input  vram_addr_t display_addr,
  output nibble_t    read_data,
  output nibble_t    display_data,
  output logic [1:0] interrupt_req
);

  // I/O page
  logic       io_write;
  logic       io_read;
  logic [7:0] io_offset;
  nibble_t    io_read_data;

  // Key interrupt control
  nibble_t    mask_k0;
  nibble_t    mask_k1;
  nibble_t    relation_k0;
  logic       factor_clear;

  // Video CPU port
  vram_addr_t vram_addr;
  logic       vram_write;
  nibble_t    vram_read_data;

  // Factor flags drive the request lines directly
  key_input u_key_input (
    .clk          (clk),
    .reset_n      (reset_n),
    .clk_en       (clk_en),
    .input_k0     (input_k0),
    .input_k1     (input_k1),
    .mask_k0      (mask_k0),
    .mask_k1      (mask_k1),
    .relation_k0  (relation_k0),
    .factor_clear (factor_clear),
    .factor       (interrupt_req)
  );

  io_registers u_io_registers (
    .clk          (clk),
    .reset_n      (reset_n),
    .clk_en       (clk_en),
    .io_write     (io_write),
    .io_read      (io_read),
    .io_offset    (io_offset),
    .write_data   (write_data),
    .input_k0     (input_k0),
    .input_k1     (input_k1),
    .factor       (interrupt_req),
    .io_read_data (io_read_data),
    .mask_k0      (mask_k0),
    .mask_k1      (mask_k1),
    .relation_k0  (relation_k0),
    .factor_clear (factor_clear)
  );

  data_bus_decode #(
    .RAM_DEPTH (RAM_DEPTH)
  ) u_data_bus_decode (
    .clk            (clk),
    .reset_n        (reset_n),
    .clk_en         (clk_en),
    .write_en       (write_en),
    .read_en        (read_en),
    .mem_addr       (mem_addr),
    .write_data     (write_data),
    .io_read_data   (io_read_data),
    .vram_read_data (vram_read_data),
    .read_data      (read_data),
    .io_write       (io_write),
    .io_read        (io_read),
    .io_offset      (io_offset),
    .vram_addr      (vram_addr),
    .vram_write     (vram_write)
  );

  video_ram u_video_ram (
    .clk            (clk),
    .clk_en         (clk_en),
    .vram_addr      (vram_addr),
    .vram_write     (vram_write),
    .write_data     (write_data),
    .display_addr   (display_addr),
    .vram_read_data (vram_read_data),
    .display_data   (display_data)
  );

endmodule

// File: hw/video_ram.sv
`timescale 1ns/1ps

module video_ram
  import mcu_bus_pkg::*;
(
  input  logic       clk,
  input  logic       clk_en,
  input  vram_addr_t vram_addr,
  input  logic       vram_write,
  input  nibble_t    write_data,
  input  vram_addr_t display_addr,
  output nibble_t    vram_read_data,
  output nibble_t    display_data
);

  nibble_t mem [VRAM_DEPTH];

  vram_addr_t display_index;

  // Out of range display reads fall back to index 0
  assign display_index = (display_addr < VRAM_DEPTH) ? display_addr : '0;

  // CPU port, write-first
  always_ff @(posedge clk) begin
    if (clk_en) begin
      if (vram_write) begin
        mem[vram_addr] <= write_data;
        vram_read_data <= write_data;
      end else begin
        vram_read_data <= mem[vram_addr];
      end
    end
  end

  // Display port runs every clock
  always_ff @(posedge clk) begin
    display_data <= mem[display_index];
  end

endmodule

// File: hw/data_bus_decode.sv
`timescale 1ns/1ps

module data_bus_decode
  import mcu_bus_pkg::*;
#(
  parameter int RAM_DEPTH = RAM_DEFAULT_DEPTH
) (
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  logic       write_en,
  input  logic       read_en,
  input  mem_addr_t  mem_addr,
  input  nibble_t    write_data,
  input  nibble_t    io_read_data,
  input  nibble_t    vram_read_data,
  output nibble_t    read_data,
  output logic       io_write,
  output logic       io_read,
  output logic [7:0] io_offset,
  output vram_addr_t vram_addr,
  output logic       vram_write
);

  localparam int RAM_AW = $clog2(RAM_DEPTH);

  nibble_t ram [RAM_DEPTH];

  logic              ram_hit;
  logic              vlo_hit;
  logic              vhi_hit;
  logic              vram_hit;
  logic              io_hit;
  logic [RAM_AW-1:0] ram_index;
  logic              vram_pending;

  // Region decode
  assign ram_hit  = mem_addr < RAM_DEPTH;
  assign vlo_hit  = (mem_addr >= VRAM_LO_BASE) && (mem_addr < VRAM_LO_BASE + VRAM_SEG_SIZE);
  assign vhi_hit  = (mem_addr >= VRAM_HI_BASE) && (mem_addr < VRAM_HI_BASE + VRAM_SEG_SIZE);
  assign vram_hit = vlo_hit || vhi_hit;
  assign io_hit   = mem_addr[11:8] == IO_PAGE;

  assign ram_index = mem_addr[RAM_AW-1:0];

  // I/O page forwarding
  assign io_write  = write_en && io_hit;
  assign io_read   = read_en && io_hit;
  assign io_offset = mem_addr[7:0];

  // Upper segment follows the lower one in video memory
  always_comb begin
    if (vlo_hit) begin
      vram_addr = vram_addr_t'(mem_addr - VRAM_LO_BASE);
    end else if (vhi_hit) begin
      vram_addr = vram_addr_t'(mem_addr - VRAM_HI_BASE) + vram_addr_t'(VRAM_SEG_SIZE);
    end else begin
      vram_addr = '0;
    end
  end

  assign vram_write = write_en && vram_hit;

  // Main RAM
  always_ff @(posedge clk) begin
    if (clk_en && write_en && ram_hit) begin
      ram[ram_index] <= write_data;
    end
  end

  // Read data register
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      read_data    <= '0;
      vram_pending <= 1'b0;
    end else if (clk_en) begin
      vram_pending <= read_en && vram_hit;

      // Video output is only ready one edge after its read
      if (vram_pending) begin
        read_data <= vram_read_data;
      end

      if (read_en) begin
        if (ram_hit) begin
          read_data <= ram[ram_index];
        end else if (io_hit) begin
          read_data <= io_read_data;
        end else if (!vram_hit) begin
          // Unmapped
          read_data <= '0;
        end
      end
    end
  end

endmodule

// File: hw/io_registers.sv
`timescale 1ns/1ps

module io_registers
  import mcu_bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  logic       io_write,
  input  logic       io_read,
  input  logic [7:0] io_offset,
  input  nibble_t    write_data,
  input  nibble_t    input_k0,
  input  nibble_t    input_k1,
  input  logic [1:0] factor,
  output nibble_t    io_read_data,
  output nibble_t    mask_k0,
  output nibble_t    mask_k1,
  output nibble_t    relation_k0,
  output logic       factor_clear
);

  logic factor_offset;

  assign factor_offset = (io_offset == IO_K0_FACTOR) || (io_offset == IO_K1_FACTOR);

  // Reading either factor clears both, on the edge that completes the read
  assign factor_clear = io_read && factor_offset;

  // Writable registers
  always_ff @(posedge clk) begin
    if (!reset_n) begin
      mask_k0     <= '0;
      mask_k1     <= '0;
      relation_k0 <= 4'hF;
    end else if (clk_en && io_write) begin
      case (io_offset)
        IO_K0_MASK: begin
          mask_k0 <= write_data;
        end
        IO_K1_MASK: begin
          mask_k1 <= write_data;
        end
        IO_K0_RELATION: begin
          relation_k0 <= write_data;
        end
        default: begin
          // Read-only or unused offset
        end
      endcase
    end
  end

  // Read side, registered by the bus decoder
  always_comb begin
    case (io_offset)
      IO_K0_FACTOR: begin
        io_read_data = {3'b000, factor[0]};
      end
      IO_K1_FACTOR: begin
        io_read_data = {3'b000, factor[1]};
      end
      IO_K0_MASK: begin
        io_read_data = mask_k0;
      end
      IO_K1_MASK: begin
        io_read_data = mask_k1;
      end
      IO_K0_VALUE: begin
        io_read_data = input_k0;
      end
      IO_K0_RELATION: begin
        io_read_data = relation_k0;
      end
      IO_K1_VALUE: begin
        io_read_data = input_k1;
      end
      default: begin
        io_read_data = '0;
      end
    endcase
  end

endmodule

// File: hw/key_input.sv
`timescale 1ns/1ps

module key_input
  import mcu_bus_pkg::*;
(
  input  logic       clk,
  input  logic       reset_n,
  input  logic       clk_en,
  input  nibble_t    input_k0,
  input  nibble_t    input_k1,
  input  nibble_t    mask_k0,
  input  nibble_t    mask_k1,
  input  nibble_t    relation_k0,
  input  logic       factor_clear,
  output logic [1:0] factor
);

  nibble_t sample_k0;
  nibble_t sample_k1;
  nibble_t prev_k0;
  nibble_t prev_k1;
  logic    edge_k0;
  logic    edge_k1;

  // K0 fires on any masked change that lands away from the relation level
  assign edge_k0 = |((sample_k0 ^ prev_k0) & mask_k0 & (sample_k0 ^ relation_k0));

  // K1 only fires on a falling edge
  assign edge_k1 = |(prev_k1 & ~sample_k1 & mask_k1);

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      sample_k0 <= '0;
      sample_k1 <= '0;
      prev_k0   <= '0;
      prev_k1   <= '0;
      factor    <= 2'b00;
    end else if (clk_en) begin
      sample_k0 <= input_k0;
      sample_k1 <= input_k1;
      prev_k0   <= sample_k0;
      prev_k1   <= sample_k1;

      // A fresh edge beats a clear in the same cycle
      if (factor_clear) begin
        factor <= {edge_k1, edge_k0};
      end else begin
        factor <= factor | {edge_k1, edge_k0};
      end
    end
  end

endmodule

// File: hw/mcu_bus_pkg.sv
package mcu_bus_pkg;

  // Data path is one nibble wide
  typedef logic [3:0] nibble_t;

  // CPU data address space
  typedef logic [11:0] mem_addr_t;

  // Index into the combined video memory
  typedef logic [7:0] vram_addr_t;

  // Main RAM, 0x000 to 0x27F by default
  localparam int RAM_DEFAULT_DEPTH = 640;

  // Display segments
  localparam mem_addr_t VRAM_LO_BASE = 12'hE00;
  localparam mem_addr_t VRAM_HI_BASE = 12'hE80;
  localparam int VRAM_SEG_SIZE = 80;
  localparam int VRAM_DEPTH = 160;

  // I/O page sits at 0xFxx
  localparam logic [3:0] IO_PAGE = 4'hF;

  // Interrupt factors, read to clear
  localparam logic [7:0] IO_K0_FACTOR = 8'h04;
  localparam logic [7:0] IO_K1_FACTOR = 8'h05;

  // Interrupt masks
  localparam logic [7:0] IO_K0_MASK = 8'h14;
  localparam logic [7:0] IO_K1_MASK = 8'h15;

  // Key port values and K0 relation
  localparam logic [7:0] IO_K0_VALUE = 8'h40;
  localparam logic [7:0] IO_K0_RELATION = 8'h41;
  localparam logic [7:0] IO_K1_VALUE = 8'h42;

endpackage
